/* mem_front_macros.svh */
// shared sizing for the memory front end
// tag 0 is reserved for "no transaction", so MEM_TAG_CNT must be 2**MEM_TAG_W
// block and word widths must be whole bytes, and the word must divide the block
// definitions only, include wherever a macro is needed

`ifndef MEM_FRONT_MACROS_SVH
`define MEM_FRONT_MACROS_SVH

// memory tag width and number of tag values
`define MEM_TAG_W   4
`define MEM_TAG_CNT 16

// one memory block, and one load word inside it
`define BLOCK_W     64
`define WORD_W      32

`endif

/* mem_front_pkg.sv */
// types shared by the handlers, the arbiter and the testbench
// mem_cmd_e encoding matches the memory command bus: none, load, store
// addresses are byte addresses, alignment is done by the handlers

`include "mem_front_macros.svh"
`default_nettype none

package mem_front_pkg;

    typedef logic [31:0]             addr_t;
    typedef logic [`MEM_TAG_W-1:0]   mem_tag_t;
    typedef logic [`BLOCK_W-1:0]     mem_block_t;

    // command on the memory port
    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_cmd_e;

    // per-handler miss state
    typedef enum logic [1:0] {
        MISS_IDLE  = 2'h0,
        MISS_ISSUE = 2'h1,
        MISS_WAIT  = 2'h2
    } miss_state_e;

    ////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        mem_cmd_e   cmd;
        addr_t      addr;
        mem_block_t data;
    } mem_req_t;

    typedef struct packed {
        mem_tag_t   data_tag;
        mem_block_t data;
    } mem_ret_t;

    // arbiter answer to one handler
    typedef struct packed {
        logic     accepted;
        mem_tag_t tag;
    } port_ack_t;

    ////////////////////////////////////////////////////////////
    // user side
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic       valid;
        addr_t      addr;
        mem_block_t block;
    } fetch_rsp_t;

    typedef struct packed {
        logic       valid;
        logic       is_store;
        addr_t      addr;
        mem_block_t data;
    } data_req_t;

    typedef struct packed {
        logic              valid;
        logic              is_store;
        addr_t             addr;
        logic [`WORD_W-1:0] word;
    } data_rsp_t;

endpackage

`default_nettype wire

/* fetch_miss_unit.sv */
// instruction block miss handler, one miss in flight at a time
// a fetch_req strobe while fetch_busy is high is dropped
// fetch_rsp.addr is the block-aligned address, the low offset bits read zero
// fill is only taken when its data_tag matches the accepted tag

`timescale 1ns/1ns
`include "mem_front_macros.svh"
`default_nettype none

module fetch_miss_unit (
    input  logic                      clock,
    input  logic                      rst_n,
    input  mem_front_pkg::fetch_req_t fetch_req,
    output logic                      fetch_busy,
    output mem_front_pkg::fetch_rsp_t fetch_rsp,
    output mem_front_pkg::mem_req_t   mem_req,
    input  mem_front_pkg::port_ack_t  ack,
    input  logic                      fill_valid,
    input  mem_front_pkg::mem_ret_t   fill
);
    import mem_front_pkg::*;

    // byte offset bits inside one block
    localparam int BLK_OFS = $clog2(`BLOCK_W / 8);

    miss_state_e state;
    addr_t       req_addr;
    mem_tag_t    req_tag;
    mem_block_t  rsp_block;
    logic        rsp_valid;
    logic        take_req;
    logic        fill_hit;

    // busy until the response strobe has gone out
    assign fetch_busy = (state != MISS_IDLE) || rsp_valid;
    assign take_req   = fetch_req.valid && !fetch_busy;
    assign fill_hit   = fill_valid && (fill.data_tag == req_tag);

    ////////////////////////////////////////////////////////////
    // miss fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= MISS_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                MISS_IDLE: begin
                    if (take_req) begin
                        state <= MISS_ISSUE;
                    end
                end
                // hold the load until memory hands out a tag
                MISS_ISSUE: begin
                    if (ack.accepted) begin
                        state <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (fill_hit) begin
                        state     <= MISS_IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= MISS_IDLE;
                end
            endcase
        end
    end

    // address, tag and block capture
    always_ff @(posedge clock) begin
        if (take_req) begin
            req_addr <= {fetch_req.addr[31:BLK_OFS], {BLK_OFS{1'b0}}};
        end
        if ((state == MISS_ISSUE) && ack.accepted) begin
            req_tag <= ack.tag;
        end
        if ((state == MISS_WAIT) && fill_hit) begin
            rsp_block <= fill.data;
        end
    end

    // request toward the arbiter, only loads from this side
    always_comb begin
        mem_req.cmd  = (state == MISS_ISSUE) ? MEM_LOAD : MEM_NONE;
        mem_req.addr = req_addr;
        mem_req.data = '0;
    end

    assign fetch_rsp = '{valid: rsp_valid, addr: req_addr, block: rsp_block};

endmodule

`default_nettype wire

/* data_miss_unit.sv */
// data load/store miss handler, one access in flight at a time
// a data_req strobe while data_busy is high is dropped
// stores write a whole block and finish on acceptance, with no fill
// loads return the word picked by address bit 2, with the unaligned address

`timescale 1ns/1ns
`include "mem_front_macros.svh"
`default_nettype none

module data_miss_unit (
    input  logic                     clock,
    input  logic                     rst_n,
    input  mem_front_pkg::data_req_t data_req,
    output logic                     data_busy,
    output mem_front_pkg::data_rsp_t data_rsp,
    output mem_front_pkg::mem_req_t  mem_req,
    input  mem_front_pkg::port_ack_t ack,
    input  logic                     fill_valid,
    input  mem_front_pkg::mem_ret_t  fill
);
    import mem_front_pkg::*;

    // byte offset bits of a block, and the bit that picks the word
    localparam int BLK_OFS  = $clog2(`BLOCK_W / 8);
    localparam int WORD_SEL = $clog2(`WORD_W / 8);

    miss_state_e        state;
    addr_t              req_addr;
    logic               req_store;
    mem_block_t         req_data;
    mem_tag_t           req_tag;
    logic [`WORD_W-1:0] rsp_word;
    logic               rsp_valid;
    logic               take_req;
    logic               fill_hit;
    logic               issue_done;

    assign data_busy  = (state != MISS_IDLE) || rsp_valid;
    assign take_req   = data_req.valid && !data_busy;
    assign fill_hit   = fill_valid && (fill.data_tag == req_tag);
    assign issue_done = (state == MISS_ISSUE) && ack.accepted;

    ////////////////////////////////////////////////////////////
    // miss fsm
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= MISS_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                MISS_IDLE: begin
                    if (take_req) begin
                        state <= MISS_ISSUE;
                    end
                end
                MISS_ISSUE: begin
                    // accepted store is complete, skip the wait
                    if (ack.accepted && req_store) begin
                        state     <= MISS_IDLE;
                        rsp_valid <= 1'b1;
                    end else if (ack.accepted) begin
                        state <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (fill_hit) begin
                        state     <= MISS_IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= MISS_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // payload capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (take_req) begin
            req_addr  <= data_req.addr;
            req_store <= data_req.is_store;
            req_data  <= data_req.data;
        end
        if (issue_done) begin
            req_tag <= ack.tag;
        end
        // stores echo the word they wrote at that address
        if (issue_done && req_store) begin
            rsp_word <= req_addr[WORD_SEL] ? req_data[`BLOCK_W-1:`WORD_W]
                                           : req_data[`WORD_W-1:0];
        end
        // load word select, upper half when bit 2 is set
        if ((state == MISS_WAIT) && fill_hit) begin
            rsp_word <= req_addr[WORD_SEL] ? fill.data[`BLOCK_W-1:`WORD_W]
                                           : fill.data[`WORD_W-1:0];
        end
    end

    // memory side always sees the block-aligned address
    always_comb begin
        mem_req.cmd  = MEM_NONE;
        if (state == MISS_ISSUE) begin
            mem_req.cmd = req_store ? MEM_STORE : MEM_LOAD;
        end
        mem_req.addr = {req_addr[31:BLK_OFS], {BLK_OFS{1'b0}}};
        mem_req.data = req_data;
    end

    assign data_rsp = '{valid:    rsp_valid,
                        is_store: req_store,
                        addr:     req_addr,
                        word:     rsp_word};

endmodule

`default_nettype wire

/* mem_port_arbiter.sv */
// single tagged memory port shared by fetch and data handlers
// data wins over fetch when both request in one cycle
// tag 0 from memory is a rejection, the loser and the rejected side just hold
// returning tags without an owner table entry are dropped

`timescale 1ns/1ns
`include "mem_front_macros.svh"
`default_nettype none

module mem_port_arbiter (
    input  logic                     clock,
    input  logic                     rst_n,
    input  mem_front_pkg::mem_req_t  fetch_mem_req,
    input  mem_front_pkg::mem_req_t  data_mem_req,
    output mem_front_pkg::port_ack_t fetch_ack,
    output mem_front_pkg::port_ack_t data_ack,
    output logic                     fetch_fill_valid,
    output logic                     data_fill_valid,
    output mem_front_pkg::mem_ret_t  fill,
    output mem_front_pkg::mem_req_t  proc2mem,
    input  mem_front_pkg::mem_tag_t  mem2proc_transaction_tag,
    input  mem_front_pkg::mem_ret_t  mem2proc
);
    import mem_front_pkg::*;

    logic                    data_sel;
    logic                    accepted;
    logic                    ret_hit;
    // one entry per tag, owner 1 means data handler
    logic [`MEM_TAG_CNT-1:0] tag_valid;
    logic [`MEM_TAG_CNT-1:0] tag_owner;

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////

    assign data_sel = (data_mem_req.cmd != MEM_NONE);
    assign proc2mem = data_sel ? data_mem_req : fetch_mem_req;
    assign accepted = (proc2mem.cmd != MEM_NONE) && (mem2proc_transaction_tag != '0);

    // only the selected handler sees the accept
    assign data_ack  = '{accepted: accepted && data_sel,
                         tag:      mem2proc_transaction_tag};
    assign fetch_ack = '{accepted: accepted && !data_sel,
                         tag:      mem2proc_transaction_tag};

    ////////////////////////////////////////////////////////////
    // tag owner table
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid <= '0;
        end else begin
            if (ret_hit) begin
                tag_valid[mem2proc.data_tag] <= 1'b0;
            end
            // stores never come back, no entry
            if (accepted && (proc2mem.cmd == MEM_LOAD)) begin
                tag_valid[mem2proc_transaction_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accepted && (proc2mem.cmd == MEM_LOAD)) begin
            tag_owner[mem2proc_transaction_tag] <= data_sel;
        end
    end

    // response routing
    assign ret_hit          = (mem2proc.data_tag != '0) && tag_valid[mem2proc.data_tag];
    assign fill             = mem2proc;
    assign data_fill_valid  = ret_hit && tag_owner[mem2proc.data_tag];
    assign fetch_fill_valid = ret_hit && !tag_owner[mem2proc.data_tag];

endmodule

`default_nettype wire

/* mem_front.sv */
// memory front end top, fetch and data miss handlers on one memory port
// user strobes are single cycle with no back-pressure, watch the busy outputs
// memory accepts with a non-zero tag and returns loads with the same tag
// at most one transaction in flight per handler

`timescale 1ns/1ns
`default_nettype none

module mem_front (
    input  logic                      clock,
    input  logic                      rst_n,
    // instruction side
    input  mem_front_pkg::fetch_req_t fetch_req,
    output logic                      fetch_busy,
    output mem_front_pkg::fetch_rsp_t fetch_rsp,
    // data side
    input  mem_front_pkg::data_req_t  data_req,
    output logic                      data_busy,
    output mem_front_pkg::data_rsp_t  data_rsp,
    // memory port
    output mem_front_pkg::mem_req_t   proc2mem,
    input  mem_front_pkg::mem_tag_t   mem2proc_transaction_tag,
    input  mem_front_pkg::mem_ret_t   mem2proc
);
    import mem_front_pkg::*;

    ////////////////////////////////////////////////////////////
    // handler to arbiter wires
    ////////////////////////////////////////////////////////////

    mem_req_t  fetch_mem_req;
    mem_req_t  data_mem_req;
    port_ack_t fetch_ack;
    port_ack_t data_ack;
    logic      fetch_fill_valid;
    logic      data_fill_valid;
    // shared return bus, the valids say who owns it
    mem_ret_t  fill;

    fetch_miss_unit u_fetch_miss (
        .clock      (clock),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_busy (fetch_busy),
        .fetch_rsp  (fetch_rsp),
        .mem_req    (fetch_mem_req),
        .ack        (fetch_ack),
        .fill_valid (fetch_fill_valid),
        .fill       (fill)
    );

    data_miss_unit u_data_miss (
        .clock      (clock),
        .rst_n      (rst_n),
        .data_req   (data_req),
        .data_busy  (data_busy),
        .data_rsp   (data_rsp),
        .mem_req    (data_mem_req),
        .ack        (data_ack),
        .fill_valid (data_fill_valid),
        .fill       (fill)
    );

    // data before fetch on the port
    mem_port_arbiter u_arbiter (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .fetch_mem_req            (fetch_mem_req),
        .data_mem_req             (data_mem_req),
        .fetch_ack                (fetch_ack),
        .data_ack                 (data_ack),
        .fetch_fill_valid         (fetch_fill_valid),
        .data_fill_valid          (data_fill_valid),
        .fill                     (fill),
        .proc2mem                 (proc2mem),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc                 (mem2proc)
    );

endmodule

`default_nettype wire

/* tb_mem_model.sv */
// tagged memory model for the testbench, one command per cycle
// tag answer is combinational, 0 means rejected
// loads return a fixed number of cycles after acceptance
// unwritten blocks read as {~addr, addr} of the block address
// backing store holds DEPTH blocks, a write evicts whatever shared its slot

`timescale 1ns/1ns
`include "mem_front_macros.svh"
`default_nettype none

module tb_mem_model (
    input  logic                    clock,
    input  logic                    rst_n,
    input  mem_front_pkg::mem_req_t proc2mem,
    output mem_front_pkg::mem_tag_t mem2proc_transaction_tag,
    output mem_front_pkg::mem_ret_t mem2proc
);
    import mem_front_pkg::*;

    localparam int LATENCY    = 4;
    // about one command in REJECT_DIV is refused
    localparam int REJECT_DIV = 4;
    localparam int DEPTH      = 256;
    localparam int TAG_MAX    = `MEM_TAG_CNT - 1;

    mem_block_t              blk_data    [DEPTH];
    addr_t                   blk_addr    [DEPTH];
    logic                    blk_written [DEPTH];
    // return pipeline, stage LATENCY-1 drives mem2proc
    mem_tag_t                pipe_tag    [LATENCY];
    mem_block_t              pipe_data   [LATENCY];
    mem_tag_t                next_tag;
    logic                    reject;
    logic [`MEM_TAG_CNT-1:0] tags_in_use;
    mem_tag_t                free_tag;
    logic                    free_found;

    function automatic mem_block_t read_block(addr_t a);
        int unsigned idx;
        idx = (a >> 3) % DEPTH;
        if (blk_written[idx] && (blk_addr[idx] == a)) begin
            return blk_data[idx];
        end
        return {~a, a};
    endfunction

    ////////////////////////////////////////////////////////////
    // tag hand-out
    ////////////////////////////////////////////////////////////

    always_comb begin
        int cand;
        tags_in_use = '0;
        for (int i = 0; i < LATENCY; i++) begin
            tags_in_use[pipe_tag[i]] = 1'b1;
        end
        // rotate from next_tag, skip tags still on their way back
        free_found = 1'b0;
        free_tag   = '0;
        for (int k = 0; k < TAG_MAX; k++) begin
            cand = ((int'(next_tag) - 1 + k) % TAG_MAX) + 1;
            if (!free_found && !tags_in_use[cand]) begin
                free_found = 1'b1;
                free_tag   = mem_tag_t'(cand);
            end
        end
    end

    assign mem2proc_transaction_tag =
        ((proc2mem.cmd != MEM_NONE) && !reject && free_found) ? free_tag : '0;
    assign mem2proc = '{data_tag: pipe_tag[LATENCY-1], data: pipe_data[LATENCY-1]};

    ////////////////////////////////////////////////////////////
    // accept, store write and return pipeline
    ////////////////////////////////////////////////////////////

    always @(posedge clock or negedge rst_n) begin
        int unsigned idx;
        if (!rst_n) begin
            next_tag <= mem_tag_t'(1);
            reject   <= 1'b0;
            for (int i = 0; i < LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
            for (int i = 0; i < DEPTH; i++) begin
                blk_written[i] <= 1'b0;
            end
        end else begin
            reject <= ($urandom % REJECT_DIV) == 0;
            for (int i = LATENCY - 1; i > 0; i--) begin
                pipe_tag[i]  <= pipe_tag[i-1];
                pipe_data[i] <= pipe_data[i-1];
            end
            pipe_tag[0] <= '0;
            if (mem2proc_transaction_tag != '0) begin
                next_tag <= (free_tag == mem_tag_t'(TAG_MAX)) ? mem_tag_t'(1) : free_tag + 1'b1;
                if (proc2mem.cmd == MEM_LOAD) begin
                    pipe_tag[0]  <= free_tag;
                    pipe_data[0] <= read_block(proc2mem.addr);
                end
                // stores finish here, nothing comes back
                if (proc2mem.cmd == MEM_STORE) begin
                    idx              = (proc2mem.addr >> 3) % DEPTH;
                    blk_data[idx]    <= proc2mem.data;
                    blk_addr[idx]    <= proc2mem.addr;
                    blk_written[idx] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* mem_front_asserts.sv */
// protocol assertions for the memory front end, bound into mem_front
// keeps its own table of open loads, built from the memory port alone
// a held fetch may be displaced by a new data request, which is allowed

`timescale 1ns/1ns
`include "mem_front_macros.svh"
`default_nettype none

module mem_front_asserts (
    input logic                      clock,
    input logic                      rst_n,
    input logic                      fetch_busy,
    input logic                      data_busy,
    input mem_front_pkg::fetch_rsp_t fetch_rsp,
    input mem_front_pkg::data_rsp_t  data_rsp,
    input mem_front_pkg::mem_req_t   proc2mem,
    input mem_front_pkg::mem_req_t   data_mem_req,
    input mem_front_pkg::mem_tag_t   mem2proc_transaction_tag,
    input mem_front_pkg::mem_ret_t   mem2proc,
    input logic                      fetch_fill_valid,
    input logic                      data_fill_valid
);
    import mem_front_pkg::*;

    // loads taken by memory and not yet returned, by tag
    logic [`MEM_TAG_CNT-1:0] open_load;
    // owner of each open load, 1 for the data side
    logic [`MEM_TAG_CNT-1:0] open_data;
    logic                    load_taken;

    assign load_taken = (proc2mem.cmd == MEM_LOAD) && (mem2proc_transaction_tag != '0);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            open_load <= '0;
            open_data <= '0;
        end else begin
            // a returning tag closes its load
            if (mem2proc.data_tag != '0) begin
                open_load[mem2proc.data_tag] <= 1'b0;
            end
            // data wins the port whenever it requests
            if (load_taken) begin
                open_load[mem2proc_transaction_tag] <= 1'b1;
                open_data[mem2proc_transaction_tag] <= (data_mem_req.cmd != MEM_NONE);
            end
        end
    end

    // quiet outputs while in reset
    a_reset_quiet: assert property (@(posedge clock)
        !rst_n |-> !fetch_busy && !data_busy && !fetch_rsp.valid && !data_rsp.valid)
        else $error("busy or response valid set during reset");

    // response strobes are single cycle
    a_fetch_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_rsp.valid |=> !fetch_rsp.valid)
        else $error("fetch_rsp valid held longer than one cycle");

    a_data_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        data_rsp.valid |=> !data_rsp.valid)
        else $error("data_rsp valid held longer than one cycle");

    // rejected command is offered again unchanged
    a_hold_rejected: assert property (@(posedge clock) disable iff (!rst_n)
        (proc2mem.cmd != MEM_NONE) && (mem2proc_transaction_tag == '0)
        |=> $stable(proc2mem) || $rose(data_mem_req.cmd != MEM_NONE))
        else $error("proc2mem changed after a rejection");

    // fills only for open loads, and only to the side that issued them
    a_fetch_fill_owned: assert property (@(posedge clock) disable iff (!rst_n)
        fetch_fill_valid |-> open_load[mem2proc.data_tag] && !open_data[mem2proc.data_tag])
        else $error("fetch fill raised for a tag that fetch does not own");

    a_data_fill_owned: assert property (@(posedge clock) disable iff (!rst_n)
        data_fill_valid |-> open_load[mem2proc.data_tag] && open_data[mem2proc.data_tag])
        else $error("data fill raised for a tag that data does not own");

endmodule

bind mem_front mem_front_asserts u_asserts (
    .clock                    (clock),
    .rst_n                    (rst_n),
    .fetch_busy               (fetch_busy),
    .data_busy                (data_busy),
    .fetch_rsp                (fetch_rsp),
    .data_rsp                 (data_rsp),
    .proc2mem                 (proc2mem),
    .data_mem_req             (data_mem_req),
    .mem2proc_transaction_tag (mem2proc_transaction_tag),
    .mem2proc                 (mem2proc),
    .fetch_fill_valid         (fetch_fill_valid),
    .data_fill_valid          (data_fill_valid)
);

`default_nettype wire

/* tb_mem_front.sv */
// testbench for the memory front end, rows run one after another
// expected data comes from a reference list of the stores in the table
// unwritten blocks are expected as {~addr, addr} of the block address
// stops at the first mismatch or timeout

`timescale 1ns/1ns
`include "mem_front_macros.svh"
`default_nettype none

module tb_mem_front;
    import mem_front_pkg::*;

    localparam int          CLK_HALF = 50;
    localparam int          TIMEOUT  = 200;
    localparam int          NUM_ROWS = 11;
    localparam logic [31:0] SEED     = 32'h9d76a140;

    typedef enum logic [1:0] {
        ROW_FETCH,
        ROW_LOAD,
        ROW_STORE,
        ROW_BOTH
    } row_kind_e;

    typedef struct packed {
        row_kind_e  kind;
        addr_t      addr;
        mem_block_t data;
    } row_t;

    logic       clock;
    logic       rst_n;
    fetch_req_t fetch_req;
    logic       fetch_busy;
    fetch_rsp_t fetch_rsp;
    data_req_t  data_req;
    logic       data_busy;
    data_rsp_t  data_rsp;
    mem_req_t   proc2mem;
    mem_tag_t   mem2proc_transaction_tag;
    mem_ret_t   mem2proc;

    row_t       rows [NUM_ROWS];
    // reference stores, newest at the back
    addr_t      ref_addr [$];
    mem_block_t ref_data [$];
    int         fetch_count;
    int         data_count;
    int         exp_fetch;
    int         exp_data;

    initial begin
        clock = 1'b0;
        forever #CLK_HALF clock = ~clock;
    end

    mem_front u_mem_front (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .fetch_req                (fetch_req),
        .fetch_busy               (fetch_busy),
        .fetch_rsp                (fetch_rsp),
        .data_req                 (data_req),
        .data_busy                (data_busy),
        .data_rsp                 (data_rsp),
        .proc2mem                 (proc2mem),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc                 (mem2proc)
    );

    tb_mem_model u_mem_model (
        .clock                    (clock),
        .rst_n                    (rst_n),
        .proc2mem                 (proc2mem),
        .mem2proc_transaction_tag (mem2proc_transaction_tag),
        .mem2proc                 (mem2proc)
    );

    // every response strobe counted, duplicates show up at the end
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fetch_count <= 0;
            data_count  <= 0;
        end else begin
            fetch_count <= fetch_count + int'(fetch_rsp.valid);
            data_count  <= data_count + int'(data_rsp.valid);
        end
    end

    ////////////////////////////////////////////////////////////
    // expected values
    ////////////////////////////////////////////////////////////

    function automatic addr_t block_base(addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    function automatic mem_block_t expected_block(addr_t a);
        addr_t base;
        base = block_base(a);
        for (int i = ref_addr.size() - 1; i >= 0; i--) begin
            if (ref_addr[i] == base) begin
                return ref_data[i];
            end
        end
        return {~base, base};
    endfunction

    // bit 2 picks the upper word
    function automatic logic [31:0] pick_word(mem_block_t b, addr_t a);
        return a[2] ? b[63:32] : b[31:0];
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(posedge clock);
        while (fetch_busy || data_busy) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run("timeout: a handler stayed busy and never went idle");
            end
            @(posedge clock);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one table row
    ////////////////////////////////////////////////////////////

    task automatic run_row(row_t r);
        logic       want_f;
        logic       want_d;
        logic       got_f;
        logic       got_d;
        logic       first_seen;
        mem_cmd_e   first_cmd;
        addr_t      first_addr;
        addr_t      fetch_addr;
        fetch_rsp_t f_seen;
        data_rsp_t  d_seen;
        int         cycles;
        wait_idle();
        want_f     = (r.kind == ROW_FETCH) || (r.kind == ROW_BOTH);
        want_d     = (r.kind != ROW_FETCH);
        got_f      = 1'b0;
        got_d      = 1'b0;
        first_seen = 1'b0;
        first_cmd  = MEM_NONE;
        first_addr = '0;
        cycles     = 0;
        // paired rows fetch the next block, so the two loads differ at the port
        fetch_addr = (r.kind == ROW_BOTH) ? r.addr + 32'h8 : r.addr;
        fetch_req <= '{valid: want_f, addr: fetch_addr};
        data_req  <= '{valid: want_d, is_store: (r.kind == ROW_STORE),
                       addr: r.addr, data: r.data};
        @(posedge clock);
        fetch_req.valid <= 1'b0;
        data_req.valid  <= 1'b0;
        while ((want_f && !got_f) || (want_d && !got_d)) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_run($sformatf("timeout: row at address 0x%h never completed", r.addr));
            end
            @(posedge clock);
            // busy from the cycle after the strobe through the response cycle
            check_value("fetch_busy", fetch_busy, want_f && !got_f);
            check_value("data_busy", data_busy, want_d && !got_d);
            // first command that memory took
            if (!first_seen && (proc2mem.cmd != MEM_NONE) &&
                (mem2proc_transaction_tag != '0)) begin
                first_seen = 1'b1;
                first_cmd  = proc2mem.cmd;
                first_addr = proc2mem.addr;
            end
            if (fetch_rsp.valid) begin
                got_f  = 1'b1;
                f_seen = fetch_rsp;
            end
            if (data_rsp.valid) begin
                got_d  = 1'b1;
                d_seen = data_rsp;
            end
        end
        if (want_f) begin
            exp_fetch++;
            check_value("fetch_rsp.addr", f_seen.addr, block_base(fetch_addr));
            check_value("fetch_rsp.block", f_seen.block, expected_block(fetch_addr));
        end
        if (want_d) begin
            exp_data++;
            check_value("data_rsp.addr", d_seen.addr, r.addr);
            check_value("data_rsp.is_store", d_seen.is_store, (r.kind == ROW_STORE));
        end
        if (r.kind == ROW_STORE) begin
            ref_addr.push_back(block_base(r.addr));
            ref_data.push_back(r.data);
        end else if (want_d) begin
            check_value("data_rsp.word", d_seen.word, pick_word(expected_block(r.addr), r.addr));
        end
        // data wins the port when both arrive together
        if (r.kind == ROW_BOTH) begin
            check_value("proc2mem.cmd first accepted", first_cmd, MEM_LOAD);
            check_value("proc2mem.addr first accepted", first_addr, block_base(r.addr));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n     = 1'b0;
        fetch_req = '0;
        data_req  = '0;
        exp_fetch = 0;
        exp_data  = 0;
        void'($urandom(SEED));
        rows[0]  = '{kind: ROW_FETCH, addr: 32'h0000_1000, data: '0};
        rows[1]  = '{kind: ROW_LOAD,  addr: 32'h0000_2004, data: '0};
        rows[2]  = '{kind: ROW_LOAD,  addr: 32'h0000_2008, data: '0};
        rows[3]  = '{kind: ROW_STORE, addr: 32'h0000_3000, data: 64'hdead_beef_0123_4567};
        rows[4]  = '{kind: ROW_LOAD,  addr: 32'h0000_3004, data: '0};
        rows[5]  = '{kind: ROW_LOAD,  addr: 32'h0000_3000, data: '0};
        rows[6]  = '{kind: ROW_BOTH,  addr: 32'h0000_5004, data: '0};
        rows[7]  = '{kind: ROW_BOTH,  addr: 32'h0000_3004, data: '0};
        rows[8]  = '{kind: ROW_STORE, addr: 32'h0000_600c, data: 64'h0f1e_2d3c_4b5a_6978};
        rows[9]  = '{kind: ROW_FETCH, addr: 32'h0000_6008, data: '0};
        rows[10] = '{kind: ROW_BOTH,  addr: 32'h0000_7ff8, data: '0};
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        wait_idle();
        // each response exactly once
        check_value("fetch_rsp valid count", fetch_count, exp_fetch);
        check_value("data_rsp valid count", data_count, exp_data);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* mem_front.f */
+incdir+.
mem_front_pkg.sv
fetch_miss_unit.sv
data_miss_unit.sv
mem_port_arbiter.sv
mem_front.sv
tb_mem_model.sv
mem_front_asserts.sv
tb_mem_front.sv

/* Bender.yml */
package:
  name: mem_front

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_front_pkg.sv
      - fetch_miss_unit.sv
      - data_miss_unit.sv
      - mem_port_arbiter.sv
      - mem_front.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_model.sv
      - mem_front_asserts.sv
      - tb_mem_front.sv
